// File: logic/vlsu_pkg.sv
// vector load/store unit package with bank geometry, beat limits and control encodings
package vlsu_pkg;

    // four 32-bit data memory banks side by side
    localparam int NUM_BANKS = 4;
    localparam int WORD_W = 32;

    // one vector register is one beat across all banks
    localparam int BEAT_W = NUM_BANKS * WORD_W;

    // widest register group (lmul = 4)
    localparam int GROUP_W = 512;

    // data memory word address
    localparam int ADDR_W = 12;

    localparam int MAX_BEATS = 4;
    localparam int BEAT_IDX_W = 2;

    // unit-stride opcodes only
    typedef enum logic [1:0] {
        LSU_IDLE = 2'd0,
        LSU_VLE  = 2'd1,
        LSU_VSE  = 2'd2
    } lsu_op_e;

    typedef enum logic [1:0] {
        S_IDLE  = 2'd0,
        S_STORE = 2'd1,
        S_LOAD  = 2'd2,
        S_DRAIN = 2'd3
    } lsu_state_e;

endpackage

// File: logic/vlsu_ctrl.sv
// vector load/store control FSM sequencing beats, memory strobes, capture and done
`timescale 1ns/1ns

module vlsu_ctrl (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            start,
    input  vlsu_pkg::lsu_op_e               op,
    input  logic [2:0]                      lmul,
    output logic                            accept,
    output logic [vlsu_pkg::BEAT_IDX_W-1:0] beat_idx,
    output logic                            advance,
    output logic                            mem_write,
    output logic                            mem_read,
    output logic                            capture,
    output logic [vlsu_pkg::BEAT_IDX_W-1:0] capture_idx,
    output logic                            done,
    output logic                            busy
);

    vlsu_pkg::lsu_state_e            state;
    logic [vlsu_pkg::BEAT_IDX_W-1:0] last_idx;
    logic [vlsu_pkg::BEAT_IDX_W-1:0] lmul_last;
    logic                            strobe;
    logic                            last_beat;

    // register group size with other encodings falling back to one register
    always_comb begin
        case (lmul)
            3'd1:    lmul_last = vlsu_pkg::BEAT_IDX_W'(1);
            3'd2:    lmul_last = vlsu_pkg::BEAT_IDX_W'(vlsu_pkg::MAX_BEATS - 1);
            default: lmul_last = '0;
        endcase
    end

    assign busy = (state != vlsu_pkg::S_IDLE);
    assign accept = start && !busy && (op != vlsu_pkg::LSU_IDLE);
    assign strobe = mem_write || mem_read;
    assign last_beat = (beat_idx == last_idx);
    assign advance = strobe && !last_beat;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= vlsu_pkg::S_IDLE;
            last_idx <= '0;
            beat_idx <= '0;
            mem_write <= 1'b0;
            mem_read <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                vlsu_pkg::S_IDLE: begin
                    if (accept) begin
                        state <= (op == vlsu_pkg::LSU_VSE) ? vlsu_pkg::S_STORE : vlsu_pkg::S_LOAD;
                        last_idx <= lmul_last;
                        beat_idx <= '0;
                    end
                end
                vlsu_pkg::S_STORE, vlsu_pkg::S_LOAD: begin
                    if (!strobe) begin
                        mem_write <= (state == vlsu_pkg::S_STORE);
                        mem_read <= (state == vlsu_pkg::S_LOAD);
                    end else if (last_beat) begin
                        mem_write <= 1'b0;
                        mem_read <= 1'b0;
                        // loads wait one more cycle for the last read word
                        if (state == vlsu_pkg::S_STORE) begin
                            state <= vlsu_pkg::S_IDLE;
                            done <= 1'b1;
                        end else begin
                            state <= vlsu_pkg::S_DRAIN;
                        end
                    end else begin
                        beat_idx <= beat_idx + 1'b1;
                    end
                end
                default: begin
                    state <= vlsu_pkg::S_IDLE;
                    done <= 1'b1;
                end
            endcase
        end
    end

    // read data comes back one cycle after the strobe
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            capture <= 1'b0;
            capture_idx <= '0;
        end else begin
            capture <= mem_read;
            capture_idx <= beat_idx;
        end
    end

    a_rw_exclusive: assert property (@(posedge clk) disable iff (!nrst)
        !(mem_write && mem_read));

    a_done_pulse: assert property (@(posedge clk) disable iff (!nrst)
        done |=> !done);

    a_accept_idle: assert property (@(posedge clk) disable iff (!nrst)
        accept |=> busy);

endmodule

// File: logic/vlsu_addr_gen.sv
// bank address generator holding the base and spreading each beat over four banks
`timescale 1ns/1ns

module vlsu_addr_gen (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            accept,
    input  logic [vlsu_pkg::ADDR_W-1:0]     base_addr,
    input  logic [vlsu_pkg::BEAT_IDX_W-1:0] beat_idx,
    output logic [vlsu_pkg::ADDR_W-1:0]     bank_addr0,
    output logic [vlsu_pkg::ADDR_W-1:0]     bank_addr1,
    output logic [vlsu_pkg::ADDR_W-1:0]     bank_addr2,
    output logic [vlsu_pkg::ADDR_W-1:0]     bank_addr3
);

    logic [vlsu_pkg::ADDR_W-1:0] base_q;
    logic [vlsu_pkg::ADDR_W-1:0] beat_base;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            base_q <= '0;
        end else if (accept) begin
            base_q <= base_addr;
        end
    end

    // 4 words per beat, wraps around the top of memory
    assign beat_base = base_q + vlsu_pkg::ADDR_W'({beat_idx, 2'b00});

    assign bank_addr0 = beat_base;
    assign bank_addr1 = beat_base + vlsu_pkg::ADDR_W'(1);
    assign bank_addr2 = beat_base + vlsu_pkg::ADDR_W'(2);
    assign bank_addr3 = beat_base + vlsu_pkg::ADDR_W'(3);

endmodule

// File: logic/vlsu_store_slicer.sv
// store data slicer presenting one 128-bit beat per cycle as four bank words
`timescale 1ns/1ns

module vlsu_store_slicer (
    input  logic                         clk,
    input  logic                         nrst,
    input  logic                         accept,
    input  logic                         advance,
    input  logic [vlsu_pkg::GROUP_W-1:0] store_data,
    output logic [vlsu_pkg::WORD_W-1:0]  wdata0,
    output logic [vlsu_pkg::WORD_W-1:0]  wdata1,
    output logic [vlsu_pkg::WORD_W-1:0]  wdata2,
    output logic [vlsu_pkg::WORD_W-1:0]  wdata3
);

    logic [vlsu_pkg::GROUP_W-1:0] data_q;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            data_q <= '0;
        end else if (accept) begin
            data_q <= store_data;
        end else if (advance) begin
            // next register moves into the low slice
            data_q <= data_q >> vlsu_pkg::BEAT_W;
        end
    end

    // bank 0 gets the least significant word
    assign wdata0 = data_q[0*vlsu_pkg::WORD_W +: vlsu_pkg::WORD_W];
    assign wdata1 = data_q[1*vlsu_pkg::WORD_W +: vlsu_pkg::WORD_W];
    assign wdata2 = data_q[2*vlsu_pkg::WORD_W +: vlsu_pkg::WORD_W];
    assign wdata3 = data_q[3*vlsu_pkg::WORD_W +: vlsu_pkg::WORD_W];

endmodule

// File: logic/vlsu_load_gather.sv
// load gather assembling returned bank words into a zero-filled 512-bit register group
`timescale 1ns/1ns

module vlsu_load_gather (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            accept,
    input  vlsu_pkg::lsu_op_e               op,
    input  logic                            capture,
    input  logic [vlsu_pkg::BEAT_IDX_W-1:0] capture_idx,
    input  logic [vlsu_pkg::WORD_W-1:0]     rdata0,
    input  logic [vlsu_pkg::WORD_W-1:0]     rdata1,
    input  logic [vlsu_pkg::WORD_W-1:0]     rdata2,
    input  logic [vlsu_pkg::WORD_W-1:0]     rdata3,
    output logic [vlsu_pkg::GROUP_W-1:0]    load_data
);

    logic [vlsu_pkg::BEAT_W-1:0] beat_word;

    assign beat_word = {rdata3, rdata2, rdata1, rdata0};

    // stores leave the last load result untouched
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            load_data <= '0;
        end else if (accept && (op == vlsu_pkg::LSU_VLE)) begin
            // clear so beats past the group end read as zero
            load_data <= '0;
        end else if (capture) begin
            load_data[capture_idx*vlsu_pkg::BEAT_W +: vlsu_pkg::BEAT_W] <= beat_word;
        end
    end

    a_capture_idx: assert property (@(posedge clk) disable iff (!nrst)
        capture |-> !accept && !$isunknown({capture_idx, beat_word}));

endmodule

// File: logic/vlsu_top.sv
// vector load/store unit top connecting control, address, store and load datapaths
`timescale 1ns/1ns

module vlsu_top (
    input  logic                         clk,
    input  logic                         nrst,
    input  logic                         start,
    input  vlsu_pkg::lsu_op_e            op,
    input  logic [2:0]                   lmul,
    input  logic [vlsu_pkg::ADDR_W-1:0]  base_addr,
    input  logic [vlsu_pkg::GROUP_W-1:0] store_data,
    input  logic [vlsu_pkg::WORD_W-1:0]  rdata0,
    input  logic [vlsu_pkg::WORD_W-1:0]  rdata1,
    input  logic [vlsu_pkg::WORD_W-1:0]  rdata2,
    input  logic [vlsu_pkg::WORD_W-1:0]  rdata3,
    output logic [vlsu_pkg::ADDR_W-1:0]  bank_addr0,
    output logic [vlsu_pkg::ADDR_W-1:0]  bank_addr1,
    output logic [vlsu_pkg::ADDR_W-1:0]  bank_addr2,
    output logic [vlsu_pkg::ADDR_W-1:0]  bank_addr3,
    output logic [vlsu_pkg::WORD_W-1:0]  wdata0,
    output logic [vlsu_pkg::WORD_W-1:0]  wdata1,
    output logic [vlsu_pkg::WORD_W-1:0]  wdata2,
    output logic [vlsu_pkg::WORD_W-1:0]  wdata3,
    output logic                         mem_write,
    output logic                         mem_read,
    output logic [vlsu_pkg::GROUP_W-1:0] load_data,
    output logic                         done,
    output logic                         busy
);

    logic                            accept;
    logic [vlsu_pkg::BEAT_IDX_W-1:0] beat_idx;
    logic                            advance;
    logic                            capture;
    logic [vlsu_pkg::BEAT_IDX_W-1:0] capture_idx;

    vlsu_ctrl u_ctrl (
        .clk         (clk),
        .nrst        (nrst),
        .start       (start),
        .op          (op),
        .lmul        (lmul),
        .accept      (accept),
        .beat_idx    (beat_idx),
        .advance     (advance),
        .mem_write   (mem_write),
        .mem_read    (mem_read),
        .capture     (capture),
        .capture_idx (capture_idx),
        .done        (done),
        .busy        (busy)
    );

    vlsu_addr_gen u_addr_gen (
        .clk        (clk),
        .nrst       (nrst),
        .accept     (accept),
        .base_addr  (base_addr),
        .beat_idx   (beat_idx),
        .bank_addr0 (bank_addr0),
        .bank_addr1 (bank_addr1),
        .bank_addr2 (bank_addr2),
        .bank_addr3 (bank_addr3)
    );

    vlsu_store_slicer u_store_slicer (
        .clk        (clk),
        .nrst       (nrst),
        .accept     (accept),
        .advance    (advance),
        .store_data (store_data),
        .wdata0     (wdata0),
        .wdata1     (wdata1),
        .wdata2     (wdata2),
        .wdata3     (wdata3)
    );

    vlsu_load_gather u_load_gather (
        .clk         (clk),
        .nrst        (nrst),
        .accept      (accept),
        .op          (op),
        .capture     (capture),
        .capture_idx (capture_idx),
        .rdata0      (rdata0),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .rdata3      (rdata3),
        .load_data   (load_data)
    );

endmodule

// File: tests/tb_vlsu_mem.sv
// four-bank data memory model with strobe writes and one-cycle registered reads
`timescale 1ns/1ns

module tb_vlsu_mem #(
    parameter int DEPTH = 4096
) (
    input  logic                        clk,
    input  logic                        mem_write,
    input  logic                        mem_read,
    input  logic [vlsu_pkg::ADDR_W-1:0] addr0,
    input  logic [vlsu_pkg::ADDR_W-1:0] addr1,
    input  logic [vlsu_pkg::ADDR_W-1:0] addr2,
    input  logic [vlsu_pkg::ADDR_W-1:0] addr3,
    input  logic [vlsu_pkg::WORD_W-1:0] wdata0,
    input  logic [vlsu_pkg::WORD_W-1:0] wdata1,
    input  logic [vlsu_pkg::WORD_W-1:0] wdata2,
    input  logic [vlsu_pkg::WORD_W-1:0] wdata3,
    output logic [vlsu_pkg::WORD_W-1:0] rdata0,
    output logic [vlsu_pkg::WORD_W-1:0] rdata1,
    output logic [vlsu_pkg::WORD_W-1:0] rdata2,
    output logic [vlsu_pkg::WORD_W-1:0] rdata3
);

    logic [vlsu_pkg::WORD_W-1:0] mem [vlsu_pkg::NUM_BANKS][DEPTH];

    always @(posedge clk) begin
        if (mem_write) begin
            mem[0][addr0] <= wdata0;
            mem[1][addr1] <= wdata1;
            mem[2][addr2] <= wdata2;
            mem[3][addr3] <= wdata3;
        end
        // read data shows up one cycle after the strobe
        if (mem_read) begin
            rdata0 <= mem[0][addr0];
            rdata1 <= mem[1][addr1];
            rdata2 <= mem[2][addr2];
            rdata3 <= mem[3][addr3];
        end
    end

endmodule

// File: tests/tb_vlsu.sv
// testbench for the vector load/store unit with random operations against a bank model
`timescale 1ns/1ns

module tb_vlsu;

    localparam int MEM_DEPTH = 1 << vlsu_pkg::ADDR_W;
    localparam int NUM_OPS = 200;
    localparam int DONE_TIMEOUT = 16;

    logic                         clk;
    logic                         nrst;
    logic                         start;
    vlsu_pkg::lsu_op_e            op;
    logic [2:0]                   lmul;
    logic [vlsu_pkg::ADDR_W-1:0]  base_addr;
    logic [vlsu_pkg::GROUP_W-1:0] store_data;
    logic [vlsu_pkg::WORD_W-1:0]  rdata0;
    logic [vlsu_pkg::WORD_W-1:0]  rdata1;
    logic [vlsu_pkg::WORD_W-1:0]  rdata2;
    logic [vlsu_pkg::WORD_W-1:0]  rdata3;
    logic [vlsu_pkg::ADDR_W-1:0]  bank_addr0;
    logic [vlsu_pkg::ADDR_W-1:0]  bank_addr1;
    logic [vlsu_pkg::ADDR_W-1:0]  bank_addr2;
    logic [vlsu_pkg::ADDR_W-1:0]  bank_addr3;
    logic [vlsu_pkg::WORD_W-1:0]  wdata0;
    logic [vlsu_pkg::WORD_W-1:0]  wdata1;
    logic [vlsu_pkg::WORD_W-1:0]  wdata2;
    logic [vlsu_pkg::WORD_W-1:0]  wdata3;
    logic                         mem_write;
    logic                         mem_read;
    logic [vlsu_pkg::GROUP_W-1:0] load_data;
    logic                         done;
    logic                         busy;

    logic [31:0]                  lcg_state;
    logic [vlsu_pkg::WORD_W-1:0]  model [vlsu_pkg::NUM_BANKS][MEM_DEPTH];
    logic [vlsu_pkg::GROUP_W-1:0] exp_load;

    vlsu_top u_dut (
        .clk        (clk),
        .nrst       (nrst),
        .start      (start),
        .op         (op),
        .lmul       (lmul),
        .base_addr  (base_addr),
        .store_data (store_data),
        .rdata0     (rdata0),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .rdata3     (rdata3),
        .bank_addr0 (bank_addr0),
        .bank_addr1 (bank_addr1),
        .bank_addr2 (bank_addr2),
        .bank_addr3 (bank_addr3),
        .wdata0     (wdata0),
        .wdata1     (wdata1),
        .wdata2     (wdata2),
        .wdata3     (wdata3),
        .mem_write  (mem_write),
        .mem_read   (mem_read),
        .load_data  (load_data),
        .done       (done),
        .busy       (busy)
    );

    tb_vlsu_mem #(.DEPTH(MEM_DEPTH)) u_mem (
        .clk       (clk),
        .mem_write (mem_write),
        .mem_read  (mem_read),
        .addr0     (bank_addr0),
        .addr1     (bank_addr1),
        .addr2     (bank_addr2),
        .addr3     (bank_addr3),
        .wdata0    (wdata0),
        .wdata1    (wdata1),
        .wdata2    (wdata2),
        .wdata3    (wdata3),
        .rdata0    (rdata0),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .rdata3    (rdata3)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // registers per group with unknown codes meaning one register
    function automatic int beats_for(input logic [2:0] code);
        case (code)
            3'd1:    return 2;
            3'd2:    return 4;
            default: return 1;
        endcase
    endfunction

    function automatic int word_addr(input logic [vlsu_pkg::ADDR_W-1:0] base, input int k,
                                     input int bank);
        return (int'(base) + 4 * k + bank) % MEM_DEPTH;
    endfunction

    function automatic logic [vlsu_pkg::GROUP_W-1:0] random_group();
        logic [vlsu_pkg::GROUP_W-1:0] data;
        for (int w = 0; w < vlsu_pkg::GROUP_W / 32; w++) begin
            data[w*32 +: 32] = lcg_next();
        end
        return data;
    endfunction

    task automatic compare(input string name, input logic [vlsu_pkg::GROUP_W-1:0] expected,
                           input logic [vlsu_pkg::GROUP_W-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic compare_memory();
        for (int i = 0; i < vlsu_pkg::NUM_BANKS; i++) begin
            for (int a = 0; a < MEM_DEPTH; a++) begin
                if (u_mem.mem[i][a] !== model[i][a]) begin
                    compare($sformatf("u_mem.mem[%0d][%0d]", i, a), model[i][a],
                            u_mem.mem[i][a]);
                end
            end
        end
    endtask

    // one operation from start strobe to done with an optional start while busy
    task automatic run_op(input vlsu_pkg::lsu_op_e op_in, input logic [2:0] lmul_in,
                          input logic [vlsu_pkg::ADDR_W-1:0] base_in,
                          input logic [vlsu_pkg::GROUP_W-1:0] data_in, input bit inject);
        int          n;
        int          cycles;
        int          write_cycles;
        int          read_cycles;
        bit          got_done;
        logic [31:0] r;
        n = beats_for(lmul_in);
        cycles = 0;
        write_cycles = 0;
        read_cycles = 0;
        got_done = 1'b0;
        start = 1'b1;
        op = op_in;
        lmul = lmul_in;
        base_addr = base_in;
        store_data = data_in;
        @(posedge clk);
        #1;
        start = 1'b0;
        if (inject) begin
            compare("busy", 1, busy);
            r = lcg_next();
            start = 1'b1;
            op = r[31] ? vlsu_pkg::LSU_VLE : vlsu_pkg::LSU_VSE;
            lmul = r[30:28];
            base_addr = r[27:16];
            store_data = random_group();
        end
        while (!got_done && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            start = 1'b0;
            if (mem_write) begin
                write_cycles++;
            end
            if (mem_read) begin
                read_cycles++;
            end
            got_done = done;
        end
        if (!got_done) begin
            $display("done never arrived within %0d cycles after start", DONE_TIMEOUT);
            $display("TEST FAIL");
            $fatal(1, "timeout waiting for done");
        end
        // busy drops together with the done pulse
        compare("busy", 0, busy);
        if (op_in == vlsu_pkg::LSU_VSE) begin
            compare("store done latency", n + 1, cycles);
            compare("mem_write cycles", n, write_cycles);
            compare("mem_read cycles", 0, read_cycles);
            for (int k = 0; k < n; k++) begin
                for (int i = 0; i < vlsu_pkg::NUM_BANKS; i++) begin
                    model[i][word_addr(base_in, k, i)] =
                        data_in[k*vlsu_pkg::BEAT_W + i*vlsu_pkg::WORD_W +: vlsu_pkg::WORD_W];
                end
            end
            compare_memory();
        end else begin
            compare("load done latency", n + 2, cycles);
            compare("mem_read cycles", n, read_cycles);
            compare("mem_write cycles", 0, write_cycles);
            exp_load = '0;
            for (int k = 0; k < n; k++) begin
                for (int i = 0; i < vlsu_pkg::NUM_BANKS; i++) begin
                    exp_load[k*vlsu_pkg::BEAT_W + i*vlsu_pkg::WORD_W +: vlsu_pkg::WORD_W] =
                        model[i][word_addr(base_in, k, i)];
                end
            end
        end
        // stores must leave the previous load result alone
        compare("load_data", exp_load, load_data);
        @(posedge clk);
        #1;
        compare("done", 0, done);
        compare("busy", 0, busy);
    endtask

    initial begin
        logic [31:0]                  r;
        vlsu_pkg::lsu_op_e            op_sel;
        logic [2:0]                   lmul_sel;
        logic [vlsu_pkg::ADDR_W-1:0]  base_sel;
        logic [vlsu_pkg::GROUP_W-1:0] data_sel;
        bit                           inject;
        lcg_state = 32'h5f2e;
        nrst = 1'b0;
        start = 1'b0;
        op = vlsu_pkg::LSU_IDLE;
        lmul = 3'd0;
        base_addr = '0;
        store_data = '0;
        exp_load = '0;
        for (int i = 0; i < vlsu_pkg::NUM_BANKS; i++) begin
            for (int a = 0; a < MEM_DEPTH; a++) begin
                model[i][a] = lcg_next();
                u_mem.mem[i][a] = model[i][a];
            end
        end
        repeat (4) @(posedge clk);
        #1;
        nrst = 1'b1;
        compare("mem_write", 0, mem_write);
        compare("mem_read", 0, mem_read);
        compare("done", 0, done);
        compare("busy", 0, busy);
        compare("load_data", 0, load_data);

        for (int count = 0; count < NUM_OPS; count++) begin
            // low LCG bits repeat with a short period
            r = lcg_next();
            op_sel = r[31] ? vlsu_pkg::LSU_VLE : vlsu_pkg::LSU_VSE;
            lmul_sel = r[30:28];
            inject = (r[27:26] == 2'b00);
            r = lcg_next();
            base_sel = r[31:20];
            data_sel = random_group();
            run_op(op_sel, lmul_sel, base_sel, data_sel, inject);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: vlsu.f
logic/vlsu_pkg.sv
logic/vlsu_ctrl.sv
logic/vlsu_addr_gen.sv
logic/vlsu_store_slicer.sv
logic/vlsu_load_gather.sv
logic/vlsu_top.sv
tests/tb_vlsu_mem.sv
tests/tb_vlsu.sv
